// ==== stepper_consts.svh ====
`ifndef STEPPER_CONSTS_SVH
`define STEPPER_CONSTS_SVH

// Move buffer depth, two entries
`define MOVE_BUFFER_BITS 1
`define MOVE_BUFFER_SIZE (1 << `MOVE_BUFFER_BITS)

// Header byte command codes
`define CMD_COORDINATED_STEP    8'h01
`define CMD_MOTOR_ENABLE        8'h0a
`define CMD_CLK_DIVISOR         8'h0b
`define CMD_MOTORCONFIG         8'h10
`define CMD_MICROSTEPPER_CONFIG 8'h16
`define CMD_CHARGEPUMP          8'h17
`define CMD_BRIDGEINVERT        8'h18
`define CMD_API_VERSION         8'hfe

// Reported by the version query
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd3
`define VERSION_PATCH 8'd1

// Configuration after reset
`define DEFAULT_MICROSTEPS          3'd2
`define DEFAULT_CURRENT             8'd140
`define DEFAULT_OFFTIME             10'd810
`define DEFAULT_BLANKTIME           8'd27
`define DEFAULT_FASTDECAY_THRESHOLD 10'd706
`define DEFAULT_MINIMUM_ON_TIME     8'd54
`define DEFAULT_CURRENT_THRESHOLD   11'd1024
`define DEFAULT_CHARGEPUMP_PERIOD   8'd91
`define DEFAULT_CLOCK_DIVISOR       8'd40

// Flops per SPI pin synchronizer
`define SYNC_STAGES 2

`endif

// ==== design/spi_word_pkg.sv ====
`default_nettype none

// Types of the SPI word layer
package spi_word_pkg;

  // One 64-bit transfer unit
  // Host packs it little endian, wire order is MSB first
  typedef logic [63:0] spi_word_t;

  // Command byte, top byte of a header word
  typedef logic [7:0] cmd_t;

endpackage

`default_nettype wire

// ==== design/motion_pkg.sv ====
`default_nettype none

`include "stepper_consts.svh"

// Types for moves, driver configuration and message parsing
package motion_pkg;

  // Move length in DDA ticks
  typedef logic [63:0] tick_count_t;

  // Signed DDA rate, step fraction per tick scaled by 2^64
  typedef logic signed [63:0] dda_rate_t;

  // One buffered move, 193 bits
  typedef struct packed {
    logic        dir;
    tick_count_t duration;
    dda_rate_t   increment;
    dda_rate_t   incinc;
  } move_t;

  // Move buffer indices and per-entry toggle flags
  typedef logic [`MOVE_BUFFER_BITS-1:0] buf_index_t;
  typedef logic [`MOVE_BUFFER_SIZE-1:0] buf_flags_t;

  // Settings for the bridge and microstepper logic
  typedef struct packed {
    logic [2:0]  microsteps;
    logic [7:0]  current;
    logic [9:0]  offtime;
    logic [7:0]  blanktime;
    logic [9:0]  fastdecay_threshold;
    logic [7:0]  minimum_on_time;
    logic [10:0] current_threshold;
    logic [7:0]  chargepump_period;
    logic        invert_highside;
    logic        invert_lowside;
  } stepper_cfg_t;

  // CLK cycles per DDA tick
  typedef logic [7:0] divisor_t;

  // Position inside a multi-word message
  typedef enum logic [2:0] {
    IDLE,
    MOVE_DURATION,
    MOVE_INCREMENT,
    MOVE_INCINC,
    REPLY
  } msg_state_t;

endpackage

`default_nettype wire

// ==== design/spi_word.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_consts.svh"

module spi_word import spi_word_pkg::*; (
  input  logic      CLK,
  input  logic      resetn,
  input  logic      sck,
  input  logic      cs_n,
  input  logic      copi,
  output logic      cipo,
  input  spi_word_t tx_word,
  output spi_word_t rx_word,
  output logic      rx_valid
);

  // Pin synchronizers, newest sample in bit 0
  logic [`SYNC_STAGES-1:0] sck_sync;
  logic [`SYNC_STAGES-1:0] cs_sync;
  logic [`SYNC_STAGES-1:0] copi_sync;
  // Previous synchronized levels for edge detection
  logic sck_prev;
  logic cs_prev;
  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_active;
  // Bits taken in the current word, wraps after 64
  logic [5:0] bit_cnt;
  spi_word_t rx_shift;
  spi_word_t tx_shift;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      copi_sync <= '0;
      sck_prev  <= 1'b0;
      cs_prev   <= 1'b1;
    end else begin
      sck_sync  <= {sck_sync[`SYNC_STAGES-2:0], sck};
      cs_sync   <= {cs_sync[`SYNC_STAGES-2:0], cs_n};
      copi_sync <= {copi_sync[`SYNC_STAGES-2:0], copi};
      sck_prev  <= sck_sync[`SYNC_STAGES-1];
      cs_prev   <= cs_sync[`SYNC_STAGES-1];
    end
  end

  // Edges seen after the last synchronizer stage
  assign cs_active = ~cs_sync[`SYNC_STAGES-1];
  assign sck_rise  = sck_sync[`SYNC_STAGES-1] & ~sck_prev;
  assign sck_fall  = ~sck_sync[`SYNC_STAGES-1] & sck_prev;
  assign cs_fall   = cs_active & cs_prev;

  // Bit counter and word strobe
  always_ff @(posedge CLK) begin
    if (resetn) begin
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!cs_active) begin
        // Deselect aborts a partial word
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 6'd1;
        if (bit_cnt == 6'd63) begin
          rx_valid <= 1'b1;
        end
      end
    end
  end

  // COPI sampled on rising SCK, MSB first
  always_ff @(posedge CLK) begin
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[62:0], copi_sync[`SYNC_STAGES-1]};
      // Completed word captured together with the strobe
      if (bit_cnt == 6'd63) begin
        rx_word <= {rx_shift[62:0], copi_sync[`SYNC_STAGES-1]};
      end
    end
  end

  // CIPO shifted on falling SCK
  always_ff @(posedge CLK) begin
    if (resetn) begin
      tx_shift <= '0;
    end else if (cs_fall) begin
      // MSB ready before the first rising edge
      tx_shift <= tx_word;
    end else if (cs_active && sck_fall) begin
      // Word boundary in a continuous transfer reloads the reply
      if (bit_cnt == 6'd0) begin
        tx_shift <= tx_word;
      end else begin
        tx_shift <= {tx_shift[62:0], 1'b0};
      end
    end
  end

  assign cipo = tx_shift[63];

endmodule

`default_nettype wire

// ==== design/command_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_consts.svh"

module command_decoder import spi_word_pkg::*, motion_pkg::*; (
  input  logic         CLK,
  input  logic         resetn,
  input  spi_word_t    rx_word,
  input  logic         rx_valid,
  output spi_word_t    tx_word,
  input  dda_rate_t    encoder_count,
  input  logic         buf_full,
  output logic         wr_en,
  output move_t        wr_move,
  output stepper_cfg_t cfg,
  output divisor_t     clock_divisor,
  output logic         enable
);

  // Driver settings after reset
  localparam stepper_cfg_t CFG_DEFAULTS = '{
    microsteps:          `DEFAULT_MICROSTEPS,
    current:             `DEFAULT_CURRENT,
    offtime:             `DEFAULT_OFFTIME,
    blanktime:           `DEFAULT_BLANKTIME,
    fastdecay_threshold: `DEFAULT_FASTDECAY_THRESHOLD,
    minimum_on_time:     `DEFAULT_MINIMUM_ON_TIME,
    current_threshold:   `DEFAULT_CURRENT_THRESHOLD,
    chargepump_period:   `DEFAULT_CHARGEPUMP_PERIOD,
    invert_highside:     1'b0,
    invert_lowside:      1'b0
  };

  msg_state_t state;
  cmd_t       header;
  // Encoder count taken at the move header
  dda_rate_t  enc_snap;

  // Command sits in the top byte of a header word
  assign header = cmd_t'(rx_word[63:56]);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state         <= IDLE;
      tx_word       <= '0;
      wr_en         <= 1'b0;
      cfg           <= CFG_DEFAULTS;
      clock_divisor <= `DEFAULT_CLOCK_DIVISOR;
      enable        <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      if (rx_valid) begin
        // Each reply lasts a single word
        tx_word <= '0;
        case (state)
          IDLE: begin
            case (header)
              `CMD_COORDINATED_STEP: state <= MOVE_DURATION;
              `CMD_MOTOR_ENABLE: enable <= rx_word[0];
              `CMD_CLK_DIVISOR: clock_divisor <= rx_word[7:0];
              `CMD_MOTORCONFIG: begin
                cfg.current    <= rx_word[15:8];
                cfg.microsteps <= rx_word[2:0];
              end
              `CMD_MICROSTEPPER_CONFIG: begin
                cfg.offtime             <= rx_word[39:30];
                cfg.blanktime           <= rx_word[29:22];
                cfg.fastdecay_threshold <= rx_word[21:12];
                // Overlaps fastdecay_threshold in the host bit map
                cfg.minimum_on_time     <= rx_word[18:11];
                cfg.current_threshold   <= rx_word[10:0];
              end
              `CMD_CHARGEPUMP: cfg.chargepump_period <= rx_word[7:0];
              `CMD_BRIDGEINVERT: begin
                cfg.invert_highside <= rx_word[1];
                cfg.invert_lowside  <= rx_word[0];
              end
              `CMD_API_VERSION: begin
                // Version goes out during the next word
                tx_word <= {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
                state   <= REPLY;
              end
              default: begin
              end
            endcase
          end
          MOVE_DURATION: state <= MOVE_INCREMENT;
          MOVE_INCREMENT: begin
            // Snapshot returned while the host sends incinc
            tx_word <= spi_word_t'(enc_snap);
            state   <= MOVE_INCINC;
          end
          MOVE_INCINC: begin
            // Move dropped when no entry is free
            wr_en <= ~buf_full;
            state <= IDLE;
          end
          REPLY: state <= IDLE;
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Move fields gathered word by word
  always_ff @(posedge CLK) begin
    if (rx_valid) begin
      case (state)
        IDLE: begin
          if (header == `CMD_COORDINATED_STEP) begin
            wr_move.dir <= rx_word[0];
            enc_snap    <= encoder_count;
          end
        end
        MOVE_DURATION: wr_move.duration <= tick_count_t'(rx_word);
        MOVE_INCREMENT: wr_move.increment <= dda_rate_t'(rx_word);
        MOVE_INCINC: wr_move.incinc <= dda_rate_t'(rx_word);
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/move_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_consts.svh"

module move_buffer import motion_pkg::*; (
  input  logic  CLK,
  input  logic  resetn,
  input  logic  wr_en,
  input  move_t wr_move,
  input  logic  move_finished,
  output move_t cur_move,
  output logic  move_pending,
  output logic  buf_full,
  output logic  buffer_ready
);

  move_t      mem [`MOVE_BUFFER_SIZE];
  buf_index_t wr_idx;
  buf_index_t rd_idx;
  // Ready toggles on write, finished toggles on completion
  buf_flags_t ready_flags;
  buf_flags_t finished_flags;
  buf_flags_t pending;

  // Entry holds a move while its two flags differ
  assign pending      = ready_flags ^ finished_flags;
  assign buf_full     = &pending;
  assign buffer_ready = ~buf_full;
  assign move_pending = pending[rd_idx];
  assign cur_move     = mem[rd_idx];

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_idx         <= '0;
      rd_idx         <= '0;
      ready_flags    <= '0;
      finished_flags <= '0;
    end else begin
      // Write side, full buffer keeps its index
      if (wr_en && !buf_full) begin
        ready_flags[wr_idx] <= ~ready_flags[wr_idx];
        wr_idx              <= wr_idx + buf_index_t'(1);
      end
      // Read side retires the entry being played
      if (move_finished && move_pending) begin
        finished_flags[rd_idx] <= ~finished_flags[rd_idx];
        rd_idx                 <= rd_idx + buf_index_t'(1);
      end
    end
  end

  // Move storage
  always_ff @(posedge CLK) begin
    if (wr_en && !buf_full) begin
      mem[wr_idx] <= wr_move;
    end
  end

endmodule

`default_nettype wire

// ==== design/dda_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module dda_timer import motion_pkg::*; (
  input  logic     CLK,
  input  logic     resetn,
  input  divisor_t clock_divisor,
  input  move_t    cur_move,
  input  logic     move_pending,
  input  logic     halt,
  output logic     step,
  output logic     dir,
  output logic     move_finished
);

  logic        active;
  // Set after the last tick, finish follows one cycle later
  logic        last_r;
  divisor_t    presc;
  logic        tick;
  tick_count_t tick_cnt;
  tick_count_t duration;
  logic [63:0] acc;
  dda_rate_t   rate;
  dda_rate_t   rate_inc;
  logic [63:0] rate_mag;
  logic [64:0] acc_sum;
  logic        last_tick;

  // One tick per clock_divisor cycles, 0 and 1 both tick every cycle
  assign tick = ({1'b0, presc} + 9'd1) >= {1'b0, clock_divisor};

  // Step on carry out of the accumulator, sign only sets direction
  assign rate_mag  = rate[63] ? 64'(-rate) : 64'(rate);
  assign acc_sum   = {1'b0, acc} + {1'b0, rate_mag};
  assign last_tick = (tick_cnt + tick_count_t'(1)) >= duration;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      active        <= 1'b0;
      last_r        <= 1'b0;
      presc         <= '0;
      step          <= 1'b0;
      dir           <= 1'b0;
      move_finished <= 1'b0;
    end else begin
      step          <= 1'b0;
      move_finished <= 1'b0;
      if (!active) begin
        presc <= '0;
        // Wait a cycle after finishing so the buffer can advance
        if (move_pending && !move_finished) begin
          active <= 1'b1;
          dir    <= cur_move.dir;
        end
      end else if (halt || last_r) begin
        active        <= 1'b0;
        last_r        <= 1'b0;
        move_finished <= 1'b1;
      end else if (tick) begin
        presc <= '0;
        step  <= acc_sum[64];
        if (last_tick) begin
          last_r <= 1'b1;
        end
      end else begin
        presc <= presc + divisor_t'(1);
      end
    end
  end

  // DDA registers, loaded from the buffer head while idle
  always_ff @(posedge CLK) begin
    if (!active) begin
      if (move_pending) begin
        acc      <= '0;
        rate     <= cur_move.increment;
        rate_inc <= cur_move.incinc;
        duration <= cur_move.duration;
        tick_cnt <= '0;
      end
    end else if (tick) begin
      // Position first, then velocity
      acc      <= acc_sum[63:0];
      rate     <= rate + rate_inc;
      tick_cnt <= tick_cnt + tick_count_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== design/stepper_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_top import spi_word_pkg::*, motion_pkg::*; (
  input  logic         CLK,
  input  logic         resetn,
  input  logic         sck,
  input  logic         cs_n,
  input  logic         copi,
  input  logic         halt,
  input  dda_rate_t    encoder_count,
  output logic         cipo,
  output logic         step,
  output logic         dir,
  output logic         enable,
  output logic         buffer_ready,
  output logic         move_done,
  output stepper_cfg_t cfg
);

  // SPI word layer
  spi_word_t rx_word;
  spi_word_t tx_word;
  logic      rx_valid;
  // Decoder to buffer
  logic      wr_en;
  move_t     wr_move;
  logic      buf_full;
  divisor_t  clock_divisor;
  // Buffer to DDA, move_done doubles as the finish strobe
  move_t     cur_move;
  logic      move_pending;

  spi_word u_spi_word (
    .CLK      (CLK),
    .resetn   (resetn),
    .sck      (sck),
    .cs_n     (cs_n),
    .copi     (copi),
    .cipo     (cipo),
    .tx_word  (tx_word),
    .rx_word  (rx_word),
    .rx_valid (rx_valid)
  );

  command_decoder u_command_decoder (
    .CLK           (CLK),
    .resetn        (resetn),
    .rx_word       (rx_word),
    .rx_valid      (rx_valid),
    .tx_word       (tx_word),
    .encoder_count (encoder_count),
    .buf_full      (buf_full),
    .wr_en         (wr_en),
    .wr_move       (wr_move),
    .cfg           (cfg),
    .clock_divisor (clock_divisor),
    .enable        (enable)
  );

  move_buffer u_move_buffer (
    .CLK           (CLK),
    .resetn        (resetn),
    .wr_en         (wr_en),
    .wr_move       (wr_move),
    .move_finished (move_done),
    .cur_move      (cur_move),
    .move_pending  (move_pending),
    .buf_full      (buf_full),
    .buffer_ready  (buffer_ready)
  );

  dda_timer u_dda_timer (
    .CLK           (CLK),
    .resetn        (resetn),
    .clock_divisor (clock_divisor),
    .cur_move      (cur_move),
    .move_pending  (move_pending),
    .halt          (halt),
    .step          (step),
    .dir           (dir),
    .move_finished (move_done)
  );

endmodule

`default_nettype wire

// ==== testbench/stepper_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stepper_checker (
  input logic CLK,
  input logic resetn,
  input logic step,
  input logic move_done,
  input logic move_pending,
  input logic buffer_ready,
  input logic enable,
  input logic cipo
);

  // Failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // One-cycle step pulses only
  step_single: assert property (@(posedge CLK) disable iff (resetn) step |=> !step)
    else begin
      fail_cnt++;
      $error("step stayed high for two cycles");
    end

  // Move done is a strobe
  done_single: assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else begin
      fail_cnt++;
      $error("move_done stayed high for two cycles");
    end

  // Idle with an empty buffer, so no stepping
  idle_no_step: assert property (@(posedge CLK) disable iff (resetn)
    (buffer_ready && !move_pending) |-> !step)
    else begin
      fail_cnt++;
      $error("step pulse while no move was active");
    end

  // Output levels one cycle into reset
  reset_values: assert property (@(posedge CLK)
    resetn |=> (!step && !move_done && !enable && buffer_ready && !cipo))
    else begin
      fail_cnt++;
      $error("outputs missed their reset values");
    end

endmodule

`default_nettype wire

// ==== testbench/stepper_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "stepper_consts.svh"

module stepper_tb import spi_word_pkg::*, motion_pkg::*;;

  logic         CLK;
  logic         resetn;
  logic         sck;
  logic         cs_n;
  logic         copi;
  logic         halt;
  dda_rate_t    encoder_count;
  logic         cipo;
  logic         step;
  logic         dir;
  logic         enable;
  logic         buffer_ready;
  logic         move_done;
  stepper_cfg_t cfg;
  logic [31:0]  lfsr_state;
  int           err_cnt = 0;
  int           timeout_cnt = 0;
  int           step_cnt = 0;
  int           done_cnt = 0;
  int           wrong_dir_cnt = 0;

  stepper_top u_dut (
    .CLK           (CLK),
    .resetn        (resetn),
    .sck           (sck),
    .cs_n          (cs_n),
    .copi          (copi),
    .halt          (halt),
    .encoder_count (encoder_count),
    .cipo          (cipo),
    .step          (step),
    .dir           (dir),
    .enable        (enable),
    .buffer_ready  (buffer_ready),
    .move_done     (move_done),
    .cfg           (cfg)
  );

  bind stepper_top stepper_checker u_checker (
    .CLK          (CLK),
    .resetn       (resetn),
    .step         (step),
    .move_done    (move_done),
    .move_pending (move_pending),
    .buffer_ready (buffer_ready),
    .enable       (enable),
    .cipo         (cipo)
  );

  // 40 ns clock
  always #20 CLK = ~CLK;

  // Pulse counters, sampled away from the active edge
  always @(negedge CLK) begin
    if (step) step_cnt++;
    if (move_done) done_cnt++;
    if (step && !dir) wrong_dir_cnt++;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[62:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [127:0] actual,
                             input logic [127:0] expected);
    assert (actual === expected) else begin
      err_cnt++;
      $display("** Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // One 64-bit word at CLK/8, MSB first, CS framed
  task automatic spi_xfer(input logic [63:0] tx, output logic [63:0] rx);
    int   i;
    int   n;
    logic seen;
    rx = '0;
    cs_n = 1'b0;
    repeat (4) @(negedge CLK);
    for (i = 63; i >= 0; i--) begin
      copi = tx[i];
      sck  = 1'b0;
      repeat (4) @(negedge CLK);
      rx  = {rx[62:0], cipo};
      sck = 1'b1;
      if (i > 0) repeat (4) @(negedge CLK);
    end
    // Word strobe from the SPI layer
    seen = 1'b0;
    n = 0;
    while (!seen && n < 16) begin
      @(negedge CLK);
      seen = u_dut.u_spi_word.rx_valid;
      n++;
    end
    if (!seen) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: no word strobe after an SPI transfer", $time);
    end
    // Decoder acts one cycle after the strobe
    repeat (2) @(negedge CLK);
    sck = 1'b0;
    repeat (4) @(negedge CLK);
    cs_n = 1'b1;
    repeat (4) @(negedge CLK);
  endtask

  // Four-word coordinated step, encoder held only during the header
  task automatic send_move(input logic d, input logic [63:0] dur, input logic [63:0] inc,
                           input logic [63:0] incinc, input dda_rate_t enc,
                           output logic [63:0] snap);
    logic [63:0] rx;
    encoder_count = enc;
    spi_xfer({`CMD_COORDINATED_STEP, 55'd0, d}, rx);
    encoder_count = ~enc;
    spi_xfer(dur, rx);
    spi_xfer(inc, rx);
    spi_xfer(incinc, snap);
  endtask

  task automatic wait_done(input int target, input int limit);
    int n;
    n = 0;
    while (done_cnt < target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (done_cnt < target) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: move_done count stuck at %0d, waiting for %0d",
               $time, done_cnt, target);
    end
  endtask

  task automatic wait_steps(input int target, input int limit);
    int n;
    n = 0;
    while (step_cnt < target && n < limit) begin
      @(negedge CLK);
      n++;
    end
    if (step_cnt < target) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: only %0d step pulses seen", $time, step_cnt);
    end
  endtask

  initial begin
    stepper_cfg_t exp_cfg;
    logic [63:0]  word;
    logic [63:0]  payload;
    logic [63:0]  reply;
    dda_rate_t    enc;
    int           base_steps;
    int           base_done;
    int           n;
    int           total;
    CLK = 1'b0;
    resetn = 1'b1;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    halt = 1'b0;
    encoder_count = '0;
    lfsr_state = 32'ha398ac44;
    repeat (2) @(negedge CLK);
    resetn = 1'b0;

    // Defaults after reset
    exp_cfg = '{microsteps: `DEFAULT_MICROSTEPS, current: `DEFAULT_CURRENT,
                offtime: `DEFAULT_OFFTIME, blanktime: `DEFAULT_BLANKTIME,
                fastdecay_threshold: `DEFAULT_FASTDECAY_THRESHOLD,
                minimum_on_time: `DEFAULT_MINIMUM_ON_TIME,
                current_threshold: `DEFAULT_CURRENT_THRESHOLD,
                chargepump_period: `DEFAULT_CHARGEPUMP_PERIOD,
                invert_highside: 1'b0, invert_lowside: 1'b0};
    repeat (20) @(negedge CLK);
    check_value("cfg", cfg, exp_cfg);
    check_value("enable", enable, 1'b0);
    check_value("buffer_ready", buffer_ready, 1'b1);
    check_value("cipo", cipo, 1'b0);
    check_value("step count", step_cnt, 0);

    // Configuration words with random payloads
    payload = rand_bits(56);
    word = {`CMD_MOTORCONFIG, payload[55:0]};
    spi_xfer(word, reply);
    exp_cfg.current    = word[15:8];
    exp_cfg.microsteps = word[2:0];
    check_value("cfg after motor config", cfg, exp_cfg);
    payload = rand_bits(56);
    word = {`CMD_MICROSTEPPER_CONFIG, payload[55:0]};
    spi_xfer(word, reply);
    exp_cfg.offtime             = word[39:30];
    exp_cfg.blanktime           = word[29:22];
    exp_cfg.fastdecay_threshold = word[21:12];
    exp_cfg.minimum_on_time     = word[18:11];
    exp_cfg.current_threshold   = word[10:0];
    check_value("cfg after microstepper config", cfg, exp_cfg);
    payload = rand_bits(56);
    word = {`CMD_CHARGEPUMP, payload[55:0]};
    spi_xfer(word, reply);
    exp_cfg.chargepump_period = word[7:0];
    check_value("cfg after charge pump", cfg, exp_cfg);
    payload = rand_bits(56);
    word = {`CMD_BRIDGEINVERT, payload[55:0]};
    spi_xfer(word, reply);
    exp_cfg.invert_highside = word[1];
    exp_cfg.invert_lowside  = word[0];
    check_value("cfg after bridge invert", cfg, exp_cfg);
    payload = rand_bits(56);
    word = {`CMD_MOTOR_ENABLE, payload[55:0]};
    spi_xfer(word, reply);
    check_value("enable", enable, word[0]);
    // Flip it so both levels get seen
    word[0] = ~word[0];
    spi_xfer(word, reply);
    check_value("enable", enable, word[0]);

    // Version comes back in the following word
    spi_xfer({`CMD_API_VERSION, 56'd0}, reply);
    spi_xfer(64'd0, reply);
    check_value("version reply", reply,
                {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH});

    // 16 ticks at a quarter step each, divisor 2
    spi_xfer({`CMD_CLK_DIVISOR, 48'd0, 8'd2}, reply);
    base_steps = step_cnt;
    base_done = done_cnt;
    n = wrong_dir_cnt;
    enc = dda_rate_t'(rand_bits(64));
    send_move(1'b1, 64'd16, 64'h4000_0000_0000_0000, 64'd0, enc, reply);
    check_value("encoder snapshot reply", reply, $unsigned(enc));
    wait_done(base_done + 1, 4000);
    repeat (20) @(negedge CLK);
    check_value("step count", step_cnt - base_steps, 4);
    check_value("move_done count", done_cnt - base_done, 1);
    check_value("dir", dir, 1'b1);
    check_value("steps with dir low", wrong_dir_cnt - n, 0);

    // Two long moves fill the buffer, the third is dropped
    base_steps = step_cnt;
    base_done = done_cnt;
    enc = dda_rate_t'(rand_bits(64));
    send_move(1'b0, 64'd4000, 64'h1000_0000_0000_0000, 64'd0, enc, reply);
    check_value("buffer_ready after first move", buffer_ready, 1'b1);
    send_move(1'b0, 64'd4000, 64'h1000_0000_0000_0000, 64'd0, enc, reply);
    check_value("buffer_ready after second move", buffer_ready, 1'b0);
    send_move(1'b1, 64'd100, 64'h4000_0000_0000_0000, 64'd0, enc, reply);
    check_value("buffer_ready after third move", buffer_ready, 1'b0);
    wait_done(base_done + 2, 20000);
    repeat (200) @(negedge CLK);
    check_value("step count", step_cnt - base_steps, 500);
    check_value("move_done count", done_cnt - base_done, 2);
    check_value("buffer_ready", buffer_ready, 1'b1);
    check_value("dir", dir, 1'b0);

    // Halt in the middle of a long move, a second one queued behind it
    base_steps = step_cnt;
    base_done = done_cnt;
    enc = dda_rate_t'(rand_bits(64));
    send_move(1'b1, 64'h0010_0000, 64'h1000_0000_0000_0000, 64'd0, enc, reply);
    send_move(1'b1, 64'h0010_0000, 64'h1000_0000_0000_0000, 64'd0, enc, reply);
    check_value("buffer_ready before halt", buffer_ready, 1'b0);
    wait_steps(base_steps + 3, 2000);
    halt = 1'b1;
    @(negedge CLK);
    halt = 1'b0;
    wait_done(base_done + 1, 20);
    // Queued move takes over, stop that one as well
    base_steps = step_cnt;
    wait_steps(base_steps + 1, 2000);
    halt = 1'b1;
    @(negedge CLK);
    halt = 1'b0;
    wait_done(base_done + 2, 20);
    base_steps = step_cnt;
    repeat (100) @(negedge CLK);
    check_value("steps after halt", step_cnt - base_steps, 0);
    check_value("buffer_ready after halt", buffer_ready, 1'b1);

    total = err_cnt + timeout_cnt + u_dut.u_checker.fail_cnt;
    $display("Value errors: %0d, timeouts: %0d, assertion failures: %0d",
             err_cnt, timeout_cnt, u_dut.u_checker.fail_cnt);
    if (total == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
design/spi_word_pkg.sv
design/motion_pkg.sv
design/spi_word.sv
design/command_decoder.sv
design/move_buffer.sv
design/dda_timer.sv
design/stepper_top.sv
testbench/stepper_checker.sv
testbench/stepper_tb.sv

// ==== Bender.yml ====
package:
  name: stepper_motion

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - design/spi_word_pkg.sv
      - design/motion_pkg.sv
      - design/spi_word.sv
      - design/command_decoder.sv
      - design/move_buffer.sv
      - design/dda_timer.sv
      - design/stepper_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - testbench/stepper_checker.sv
      - testbench/stepper_tb.sv
